// File: src.f
hdl/mopshubFramePkg.sv
hdl/mopshubCheckPkg.sv
hdl/frameCapture.sv
hdl/frameClassifier.sv
hdl/responseJudge.sv
hdl/checkCounters.sv
hdl/mopshubCheckTop.sv
verification/mopshubCheckTb.sv

// File: run.sh
#!/bin/sh
# build and run the response checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module mopshubCheckTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

// File: verification/mopshubCheckTb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the response checker: clock, reset, LFSR, stimulus table,
// value compare and result report
////////////////////////////////////////////////////////////////////////////
module mopshubCheckTb
  import mopshubFramePkg::*;
  import mopshubCheckPkg::*;
();

  localparam int CountWidth = 16;
  localparam int NumTests = 17;
  localparam int Timeout = 10;
  localparam logic [7:0] BusUnderTest = 8'h3C;

  typedef struct packed {
    logic     trim;
    canFrameT req;
    canFrameT resp;
    checkCatT cat;
    logic     pass;
  } stimT;

  logic                  clk;
  logic                  rst;
  logic                  reqMsg;
  canFrameT              requestData;
  logic                  respMsg;
  canFrameT              responseData;
  logic                  trimMode;
  logic [7:0]            busId;
  logic                  verdictValid;
  verdictT               verdict;
  logic [CountWidth-1:0] passCount;
  logic [CountWidth-1:0] failCount;
  logic                  anyFail;

  stimT        stimTable [NumTests];
  string       testName [NumTests];
  int          entryCount = 0;
  int          errorCount = 0;
  int          expPass = 0;
  int          expFail = 0;
  logic        timedOut = 1'b0;
  logic [31:0] lfsrState = 32'haf1dac1c;

  mopshubCheckTop #(
    .CountWidth (CountWidth)
  ) DUT (
    .clk          (clk),
    .rst          (rst),
    .reqMsg       (reqMsg),
    .requestData  (requestData),
    .respMsg      (respMsg),
    .responseData (responseData),
    .trimMode     (trimMode),
    .busId        (busId),
    .verdictValid (verdictValid),
    .verdict      (verdict),
    .passCount    (passCount),
    .failCount    (failCount),
    .anyFail      (anyFail)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1, right-shifting form
  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic randomBits(input int n, output logic [FrameWidth-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsrState = galoisStep(lfsrState);
      v = {v[FrameWidth-2:0], lfsrState[0]};
    end
  endtask

  function automatic canFrameT sdoFrame(input logic [11:0] cobId, input logic [7:0] command,
                                        input logic [15:0] index, input logic [7:0] subIndex,
                                        input logic [27:0] data);
    canFrameT f;
    f.sdo.cobId = cobId;
    f.sdo.dlc = 4'h8;
    f.sdo.command = command;
    f.sdo.index = index;
    f.sdo.subIndex = subIndex;
    f.sdo.data = data;
    return f;
  endfunction

  function automatic canFrameT guardFrame(input logic [11:0] cobId, input logic [3:0] dlc,
                                          input logic [7:0] nodeState);
    canFrameT f;
    f.raw = '0;
    f.nmt.cobId = cobId;
    f.nmt.dlc = dlc;
    f.nmt.nodeState = nodeState;
    return f;
  endfunction

  task automatic addEntry(input string name, input logic trim, input canFrameT req,
                          input canFrameT resp, input checkCatT cat, input logic pass);
    stimTable[entryCount] = '{trim: trim, req: req, resp: resp, cat: cat, pass: pass};
    testName[entryCount] = name;
    entryCount++;
  endtask

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic buildTable();
    canFrameT               req;
    canFrameT               resp;
    logic [FrameWidth-1:0]  bits;
    int                     flip;
    req = guardFrame(12'h705, 4'h0, 8'h00);
    addEntry("guard ok", 1'b0, req, guardFrame(12'h705, 4'h1, 8'h85), catNodeGuard, 1'b1);
    addEntry("guard stopped", 1'b0, req, guardFrame(12'h705, 4'h1, 8'h84), catNodeGuard, 1'b0);
    // four known dictionary entries on node 1
    req = sdoFrame(12'h601, 8'h40, 16'h1000, 8'h00, 28'h0);
    addEntry("sdo 1000/0", 1'b0, req, sdoFrame(12'h581, 8'h43, 16'h1000, 8'h00, 28'h0000191),
             catSdoRead, 1'b1);
    req = sdoFrame(12'h601, 8'h40, 16'h1018, 8'h01, 28'h0);
    addEntry("sdo 1018/1", 1'b0, req, sdoFrame(12'h581, 8'h43, 16'h1018, 8'h01, 28'h0000001),
             catSdoRead, 1'b1);
    req = sdoFrame(12'h601, 8'h40, 16'h1400, 8'h01, 28'h0);
    addEntry("sdo 1400/1", 1'b0, req, sdoFrame(12'h581, 8'h4F, 16'h1400, 8'h01, 28'h0000581),
             catSdoRead, 1'b1);
    req = sdoFrame(12'h601, 8'h40, 16'h1800, 8'h01, 28'h0);
    addEntry("sdo 1800/1", 1'b0, req, sdoFrame(12'h581, 8'h43, 16'h1800, 8'h01, 28'h0000181),
             catSdoRead, 1'b1);
    // unknown index, only the structure is judged
    req = sdoFrame(12'h601, 8'h40, 16'h2001, 8'h00, 28'h0);
    addEntry("sdo unknown", 1'b0, req, sdoFrame(12'h581, 8'h4B, 16'h2001, 8'h00, 28'h00000AB),
             catSdoRead, 1'b1);
    req = sdoFrame(12'h601, 8'h40, 16'h1000, 8'h00, 28'h0);
    addEntry("sdo bad cobid", 1'b0, req, sdoFrame(12'h582, 8'h43, 16'h1000, 8'h00, 28'h0000191),
             catSdoRead, 1'b0);
    req = sdoFrame(12'h601, 8'h40, 16'h1018, 8'h01, 28'h0);
    addEntry("sdo bad index", 1'b0, req, sdoFrame(12'h581, 8'h43, 16'h1019, 8'h01, 28'h0000001),
             catSdoRead, 1'b0);
    req = sdoFrame(12'h601, 8'h40, 16'h1400, 8'h01, 28'h0);
    addEntry("sdo bad data", 1'b0, req, sdoFrame(12'h581, 8'h43, 16'h1400, 8'h01, 28'h0000582),
             catSdoRead, 1'b0);
    // trim mode ignores requestData
    req.raw = '0;
    resp.raw = TrimPattern;
    resp.sdo.data[27:20] = BusUnderTest;
    addEntry("trim ok", 1'b1, req, resp, catTrim, 1'b1);
    resp.sdo.data[27:20] = BusUnderTest ^ 8'h01;
    addEntry("trim bad bus", 1'b1, req, resp, catTrim, 1'b0);
    for (int e = 0; e < 5; e++)
    begin
      randomBits(FrameWidth, bits);
      req.raw = bits;
      // pdo id keeps the request out of the other categories
      req.sdo.cobId = 12'h181;
      resp = req;
      if (e < 3)
      begin
        randomBits(8, bits);
        resp.raw[7:0] = req.raw[7:0] ^ (bits[7:0] | 8'h01);
        addEntry("echo low byte", 1'b0, req, resp, catEcho, 1'b1);
      end
      else
      begin
        randomBits(7, bits);
        flip = 8 + int'(bits[6:0]) % (FrameWidth - 8);
        resp.raw[flip] = ~resp.raw[flip];
        addEntry("echo high bit", 1'b0, req, resp, catEcho, 1'b0);
      end
    end
  endtask

  task automatic waitVerdict(output int cycles, output logic found);
    cycles = 0;
    while (verdictValid !== 1'b1 && cycles < Timeout)
    begin
      @(posedge clk);
      #2;
      cycles++;
    end
    found = (verdictValid === 1'b1);
  endtask

  task automatic checkCounts();
    compareValue("passCount", 32'(passCount), 32'(expPass));
    compareValue("failCount", 32'(failCount), 32'(expFail));
    compareValue("anyFail", 32'(anyFail), 32'(expFail > 0));
  endtask

  initial
  begin
    int   cycles;
    int   errBefore;
    logic found;
    rst = 1'b0;
    reqMsg = 1'b0;
    respMsg = 1'b0;
    requestData = '0;
    responseData = '0;
    trimMode = 1'b0;
    busId = BusUnderTest;
    buildTable();
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b1;
    compareValue("verdictValid", 32'(verdictValid), 32'd0);
    checkCounts();

    for (int k = 0; k < entryCount && !timedOut; k++)
    begin
      errBefore = errorCount;
      @(posedge clk);
      #2;
      trimMode = stimTable[k].trim;
      requestData = stimTable[k].req;
      reqMsg = 1'b1;
      @(posedge clk);
      #2;
      reqMsg = 1'b0;
      responseData = stimTable[k].resp;
      respMsg = 1'b1;
      @(posedge clk);
      #2;
      respMsg = 1'b0;
      waitVerdict(cycles, found);
      if (!found)
      begin
        $display("test %0d %s: no verdict within %0d cycles", k, testName[k], Timeout);
        timedOut = 1'b1;
      end
      else
      begin
        // strobe cycle itself is not counted by the wait
        compareValue("latency", 32'(cycles + 1), 32'd3);
        compareValue("verdict.category", 32'(verdict.category), 32'(stimTable[k].cat));
        compareValue("verdict.pass", 32'(verdict.pass), 32'(stimTable[k].pass));
        if (stimTable[k].pass)
          expPass++;
        else
          expFail++;
        @(posedge clk);
        #2;
        compareValue("verdictValid", 32'(verdictValid), 32'd0);
        checkCounts();
        $display("test %0d %s: %s", k, testName[k], errorCount == errBefore ? "ok" : "failed");
      end
    end

    // two responses in a row, both paired with the same request
    if (!timedOut)
    begin
      errBefore = errorCount;
      @(posedge clk);
      #2;
      trimMode = 1'b0;
      requestData = sdoFrame(12'h601, 8'h40, 16'h1000, 8'h00, 28'h0);
      reqMsg = 1'b1;
      @(posedge clk);
      #2;
      reqMsg = 1'b0;
      responseData = sdoFrame(12'h581, 8'h43, 16'h1000, 8'h00, 28'h0000191);
      respMsg = 1'b1;
      @(posedge clk);
      #2;
      responseData = sdoFrame(12'h581, 8'h43, 16'h1000, 8'h00, 28'h0000192);
      @(posedge clk);
      #2;
      respMsg = 1'b0;
      waitVerdict(cycles, found);
      if (!found)
      begin
        $display("test back-to-back: no verdict within %0d cycles", Timeout);
        timedOut = 1'b1;
      end
      else
      begin
        // two strobe cycles pass before the wait starts
        compareValue("latency", 32'(cycles + 2), 32'd3);
        compareValue("verdict.category", 32'(verdict.category), 32'(catSdoRead));
        compareValue("verdict.pass", 32'(verdict.pass), 32'd1);
        @(posedge clk);
        #2;
        compareValue("verdictValid", 32'(verdictValid), 32'd1);
        compareValue("verdict.category", 32'(verdict.category), 32'(catSdoRead));
        compareValue("verdict.pass", 32'(verdict.pass), 32'd0);
        expPass++;
        expFail++;
        @(posedge clk);
        #2;
        compareValue("verdictValid", 32'(verdictValid), 32'd0);
        checkCounts();
        $display("test back-to-back: %s", errorCount == errBefore ? "ok" : "failed");
      end
    end

    $display("summary: %0d table entries, %0d errors, passCount %0d, failCount %0d",
             entryCount, errorCount, passCount, failCount);
    if (errorCount == 0 && !timedOut)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: hdl/mopshubCheckTop.sv
////////////////////////////////////////////////////////////////////////////
// response checker top, capture/classify/judge pipeline and counters
////////////////////////////////////////////////////////////////////////////
module mopshubCheckTop
  import mopshubFramePkg::*;
  import mopshubCheckPkg::*;
#(
  parameter int CountWidth = 16
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  reqMsg,
  input  canFrameT              requestData,
  input  logic                  respMsg,
  input  canFrameT              responseData,
  input  logic                  trimMode,
  input  logic [7:0]            busId,
  output logic                  verdictValid,
  output verdictT               verdict,
  output logic [CountWidth-1:0] passCount,
  output logic [CountWidth-1:0] failCount,
  output logic                  anyFail
);

  logic     pairValid;
  canFrameT reqFrame;
  canFrameT respFrame;
  logic     classValid;
  checkCatT category;
  canFrameT catReq;
  canFrameT catResp;

  frameCapture uCapture (
    .clk          (clk),
    .rst          (rst),
    .reqMsg       (reqMsg),
    .requestData  (requestData),
    .respMsg      (respMsg),
    .responseData (responseData),
    .trimMode     (trimMode),
    .pairValid    (pairValid),
    .reqFrame     (reqFrame),
    .respFrame    (respFrame)
  );

  frameClassifier uClassifier (
    .clk        (clk),
    .rst        (rst),
    .pairValid  (pairValid),
    .reqFrame   (reqFrame),
    .respFrame  (respFrame),
    .classValid (classValid),
    .category   (category),
    .catReq     (catReq),
    .catResp    (catResp)
  );

  responseJudge uJudge (
    .clk          (clk),
    .rst          (rst),
    .classValid   (classValid),
    .category     (category),
    .catReq       (catReq),
    .catResp      (catResp),
    .busId        (busId),
    .verdictValid (verdictValid),
    .verdict      (verdict)
  );

  checkCounters #(
    .CountWidth (CountWidth)
  ) uCounters (
    .clk          (clk),
    .rst          (rst),
    .verdictValid (verdictValid),
    .verdict      (verdict),
    .passCount    (passCount),
    .failCount    (failCount),
    .anyFail      (anyFail)
  );

endmodule

// File: hdl/checkCounters.sv
////////////////////////////////////////////////////////////////////////////
// saturating pass/fail counters and sticky failure flag
////////////////////////////////////////////////////////////////////////////
module checkCounters
  import mopshubCheckPkg::*;
#(
  parameter int CountWidth = 16
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  verdictValid,
  input  verdictT               verdict,
  output logic [CountWidth-1:0] passCount,
  output logic [CountWidth-1:0] failCount,
  output logic                  anyFail
);

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      passCount <= '0;
      failCount <= '0;
      anyFail   <= 1'b0;
    end
    else if (verdictValid)
    begin
      if (verdict.pass)
      begin
        if (passCount != '1)
          passCount <= passCount + 1'b1;
      end
      else
      begin
        anyFail <= 1'b1;
        // hold at all ones
        if (failCount != '1)
          failCount <= failCount + 1'b1;
      end
    end
  end

  failMonotonic: assert property (@(posedge clk) disable iff (!rst)
    $past(rst) |-> failCount >= $past(failCount));

endmodule

// File: hdl/responseJudge.sv
////////////////////////////////////////////////////////////////////////////
// per-category response rules and reference table lookup, verdict register
////////////////////////////////////////////////////////////////////////////
module responseJudge
  import mopshubFramePkg::*;
  import mopshubCheckPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       classValid,
  input  checkCatT   category,
  input  canFrameT   catReq,
  input  canFrameT   catResp,
  input  logic [7:0] busId,
  output logic       verdictValid,
  output verdictT    verdict
);

  canFrameT    trimExpect;
  logic [11:0] sdoRespCobId;
  logic        refHit;
  logic        refMatch;
  logic        guardOk;
  logic        sdoOk;
  logic        pass;

  // trim echo comes back with the bus byte filled in
  always_comb
  begin
    trimExpect.raw = TrimPattern;
    trimExpect.sdo.data[27:20] = busId;
  end

  assign sdoRespCobId = SdoResponseBase + {5'd0, catReq.sdo.cobId[6:0]};

  always_comb
  begin
    refHit   = 1'b0;
    refMatch = 1'b0;
    for (int i = 0; i < RefCount; i++)
    begin
      if (catReq.sdo.index == RefTable[i].index &&
          catReq.sdo.subIndex == RefTable[i].subIndex)
      begin
        refHit   = 1'b1;
        refMatch = (catResp.sdo.data == RefTable[i].data);
      end
    end
  end

  assign guardOk = (catResp.nmt.cobId == catReq.nmt.cobId) &&
                   (catResp.nmt.nodeState[6:0] == NodeOperational);

  // unknown indices get the structural check only
  assign sdoOk = (catResp.sdo.cobId == sdoRespCobId) &&
                 (catResp.sdo.command inside {SdoUploadResp4, SdoUploadResp2,
                                              SdoUploadResp1}) &&
                 (catResp.sdo.index == catReq.sdo.index) &&
                 (catResp.sdo.subIndex == catReq.sdo.subIndex) &&
                 (!refHit || refMatch);

  always_comb
  begin
    case (category)
      catNodeGuard: pass = guardOk;
      catSdoRead:   pass = sdoOk;
      catTrim:      pass = (catResp.raw == trimExpect.raw);
      default:      pass = (catResp.raw[FrameWidth-1:8] == catReq.raw[FrameWidth-1:8]);
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
      verdictValid <= 1'b0;
    else
      verdictValid <= classValid;
  end

  always_ff @(posedge clk)
  begin
    if (classValid)
    begin
      verdict.category <= category;
      verdict.pass     <= pass;
    end
  end

  // every verdict traces back to a classified pair
  verdictFromClass: assert property (@(posedge clk) disable iff (!rst)
    verdictValid |-> $past(classValid));

endmodule

// File: hdl/frameClassifier.sv
////////////////////////////////////////////////////////////////////////////
// request decode into check category, one register stage
////////////////////////////////////////////////////////////////////////////
module frameClassifier
  import mopshubFramePkg::*;
  import mopshubCheckPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     pairValid,
  input  canFrameT reqFrame,
  input  canFrameT respFrame,
  output logic     classValid,
  output checkCatT category,
  output canFrameT catReq,
  output canFrameT catResp
);

  checkCatT    nextCat;
  logic [11:0] reqBase;

  // strip node number
  assign reqBase = {reqFrame.sdo.cobId[11:7], 7'h00};

  always_comb
  begin
    if (reqFrame.raw == TrimPattern)
      nextCat = catTrim;
    else if (reqBase == NodeGuardBase && reqFrame.nmt.dlc == 4'h0)
      nextCat = catNodeGuard;
    else if (reqBase == SdoRequestBase && reqFrame.sdo.command == SdoUploadRequest)
      nextCat = catSdoRead;
    else
      nextCat = catEcho;
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
      classValid <= 1'b0;
    else
      classValid <= pairValid;
  end

  always_ff @(posedge clk)
  begin
    if (pairValid)
    begin
      category <= nextCat;
      catReq   <= reqFrame;
      catResp  <= respFrame;
    end
  end

endmodule

// File: hdl/frameCapture.sv
////////////////////////////////////////////////////////////////////////////
// request hold register and request/response pairing stage
////////////////////////////////////////////////////////////////////////////
module frameCapture
  import mopshubFramePkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     reqMsg,
  input  canFrameT requestData,
  input  logic     respMsg,
  input  canFrameT responseData,
  input  logic     trimMode,
  output logic     pairValid,
  output canFrameT reqFrame,
  output canFrameT respFrame
);

  canFrameT reqHold;
  logic     reqSeen;

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      pairValid <= 1'b0;
      reqSeen   <= 1'b0;
    end
    else
    begin
      pairValid <= respMsg;
      if (reqMsg)
        reqSeen <= 1'b1;
    end
  end

  // same-cycle request lands in reqHold, response takes the older one
  always_ff @(posedge clk)
  begin
    if (reqMsg)
    begin
      if (trimMode)
        reqHold.raw <= TrimPattern;
      else
        reqHold <= requestData;
    end
    if (respMsg)
    begin
      reqFrame  <= reqHold;
      respFrame <= responseData;
    end
  end

  // a response needs some earlier request to pair with
  respAfterReq: assert property (@(posedge clk) disable iff (!rst)
    respMsg |-> reqSeen);

endmodule

// File: hdl/mopshubCheckPkg.sv
////////////////////////////////////////////////////////////////////////////
// check categories, verdict record and expected node state
////////////////////////////////////////////////////////////////////////////
package mopshubCheckPkg;

  // one category per response rule
  typedef enum logic [1:0] {
    catNodeGuard,
    catSdoRead,
    catTrim,
    catEcho
  } checkCatT;

  typedef struct packed {
    checkCatT category;
    logic     pass;
  } verdictT;

  // node state without toggle bit
  localparam logic [6:0] NodeOperational = 7'h05;

endpackage

// File: hdl/mopshubFramePkg.sv
////////////////////////////////////////////////////////////////////////////
// CAN frame layout, SDO/NMT frame union, object-ID bases, trim pattern
// and reference table of known object-dictionary values
////////////////////////////////////////////////////////////////////////////
package mopshubFramePkg;

  localparam int FrameWidth = 76;

  // SDO view, top byte of data carries the bus id
  typedef struct packed {
    logic [11:0] cobId;
    logic [3:0]  dlc;
    logic [7:0]  command;
    logic [15:0] index;
    logic [7:0]  subIndex;
    logic [27:0] data;
  } sdoFrameT;

  // node guard view, nodeState[7] is the toggle bit
  typedef struct packed {
    logic [11:0] cobId;
    logic [3:0]  dlc;
    logic [7:0]  nodeState;
    logic [51:0] rest;
  } nmtFrameT;

  typedef union packed {
    sdoFrameT              sdo;
    nmtFrameT              nmt;
    logic [FrameWidth-1:0] raw;
  } canFrameT;

  // object-ID bases, node number sits in the low 7 bits
  localparam logic [11:0] SdoRequestBase  = 12'h600;
  localparam logic [11:0] SdoResponseBase = 12'h580;
  localparam logic [11:0] NodeGuardBase   = 12'h700;
  localparam logic [11:0] TrimCobId       = 12'h555;

  localparam logic [7:0] SdoUploadRequest = 8'h40;
  localparam logic [7:0] SdoUploadResp4   = 8'h43;
  localparam logic [7:0] SdoUploadResp2   = 8'h4B;
  localparam logic [7:0] SdoUploadResp1   = 8'h4F;

  localparam logic [FrameWidth-1:0] TrimPattern = {TrimCobId, {16{4'hA}}};

  typedef struct packed {
    logic [15:0] index;
    logic [7:0]  subIndex;
    logic [27:0] data;
  } refEntryT;

  localparam int RefCount = 4;

  // device type, vendor id, rx/tx pdo cob ids
  localparam refEntryT RefTable [RefCount] = '{
    '{index: 16'h1000, subIndex: 8'h00, data: 28'h0000191},
    '{index: 16'h1018, subIndex: 8'h01, data: 28'h0000001},
    '{index: 16'h1400, subIndex: 8'h01, data: 28'h0000581},
    '{index: 16'h1800, subIndex: 8'h01, data: 28'h0000181}
  };

endpackage
